/* logic/uart_pkg.sv */
package uart_pkg;

    // one data byte on the serial line
    typedef logic [7:0] byte_t;

    // protocol words go out low byte first
    localparam int BYTES_PER_WORD = 4;

    // level of an idle line and of every stop bit
    localparam logic LINE_IDLE = 1'b1;

endpackage

/* logic/dbg_pkg.sv */
package dbg_pkg;

    typedef logic [31:0] word_t;

    // anything else in the opcode byte is answered with an error word
    typedef enum logic [7:0] {
        OP_LOAD = 8'h01,
        OP_STEP = 8'h02,
        OP_DUMP = 8'h03
    } opcode_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [7:0]  count;
        logic [15:0] arg;
    } cmd_t;

    // host word seen as a command or as an instruction for imem
    typedef union packed {
        cmd_t  cmd;
        word_t instr;
    } rx_word_u;

    // count or bad opcode goes into the low byte
    localparam word_t REPLY_ACK = 32'hACC0_0000;
    localparam word_t REPLY_ERR = 32'hEE00_0000;

endpackage

/* logic/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            rx,
    output uart_pkg::byte_t rx_byte,
    output logic            rx_byte_valid
);

    localparam int CW = $clog2(CLKS_PER_BIT) + 1;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]    state;
    logic [1:0]    sync;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic          rx_s;
    logic          sample;

    assign rx_s = sync[1];

    // mid-bit strobe, half a period into the start bit
    assign sample = (state == S_START) ? (cnt == CW'((CLKS_PER_BIT - 1) / 2))
                                       : (cnt == CW'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sync          <= {2{uart_pkg::LINE_IDLE}};
            state         <= S_IDLE;
            cnt           <= '0;
            bit_idx       <= '0;
            rx_byte_valid <= 1'b0;
        end
        else
        begin
            sync          <= {sync[0], rx};
            rx_byte_valid <= 1'b0;
            cnt           <= sample ? '0 : cnt + 1'b1;
            case (state)
                S_IDLE:
                begin
                    cnt <= '0;
                    if (rx_s != uart_pkg::LINE_IDLE)
                        state <= S_START;
                end
                S_START:
                    // a glitch shorter than half a bit goes back to idle
                    if (sample)
                        state <= (rx_s != uart_pkg::LINE_IDLE) ? S_DATA : S_IDLE;
                S_DATA:
                    if (sample)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= S_STOP;
                    end
                default:
                    if (sample)
                    begin
                        // low stop bit means framing error, byte dropped
                        rx_byte_valid <= (rx_s == uart_pkg::LINE_IDLE);
                        state         <= S_IDLE;
                    end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk)
    begin
        if (state == S_DATA && sample)
            rx_byte <= {rx_s, rx_byte[7:1]};
    end

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::byte_t tx_byte,
    input  logic            tx_byte_valid,
    output logic            tx_ready,
    output logic            tx
);

    localparam int CW = $clog2(CLKS_PER_BIT) + 1;

    logic          busy;
    logic [CW-1:0] cnt;
    logic [3:0]    bit_idx;
    logic [8:0]    shift;
    logic          bit_end;

    assign tx_ready = !busy;
    assign bit_end  = (cnt == CW'(CLKS_PER_BIT - 1));

    // start bit goes out on accept, then 8 data bits and the stop bit
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= uart_pkg::LINE_IDLE;
        end
        else if (!busy)
        begin
            cnt     <= '0;
            bit_idx <= '0;
            if (tx_byte_valid)
            begin
                busy <= 1'b1;
                tx   <= !uart_pkg::LINE_IDLE;
            end
        end
        else if (bit_end)
        begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd9)
                busy <= 1'b0;
            else
                tx <= shift[0];
        end
        else
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!busy && tx_byte_valid)
            shift <= {uart_pkg::LINE_IDLE, tx_byte};
        else if (busy && bit_end)
            shift <= {uart_pkg::LINE_IDLE, shift[8:1]};
    end

    a_idle_line: assert property (@(posedge clk) disable iff (rst)
        tx_ready |-> tx == uart_pkg::LINE_IDLE);

endmodule

/* logic/word_assembler.sv */
`timescale 1ns/1ps

module word_assembler (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::byte_t rx_byte,
    input  logic            rx_byte_valid,
    output dbg_pkg::word_t  rx_word,
    output logic            rx_word_valid,
    input  logic            rx_word_ready
);

    localparam int NW = $clog2(uart_pkg::BYTES_PER_WORD);

    logic [NW-1:0] n_bytes;
    logic          take;

    // while a finished word waits, new bytes are lost
    assign take = rx_byte_valid && !rx_word_valid;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            n_bytes       <= '0;
            rx_word_valid <= 1'b0;
        end
        else
        begin
            if (rx_word_valid && rx_word_ready)
                rx_word_valid <= 1'b0;
            if (take)
            begin
                if (n_bytes == NW'(uart_pkg::BYTES_PER_WORD - 1))
                begin
                    n_bytes       <= '0;
                    rx_word_valid <= 1'b1;
                end
                else
                    n_bytes <= n_bytes + 1'b1;
            end
        end
    end

    // low byte first, so shift in from the top
    always_ff @(posedge clk)
    begin
        if (take)
            rx_word <= {rx_byte, rx_word[31:8]};
    end

endmodule

/* logic/word_serializer.sv */
`timescale 1ns/1ps

module word_serializer (
    input  logic            clk,
    input  logic            rst,
    input  dbg_pkg::word_t  reply_word,
    input  logic            reply_valid,
    output logic            reply_ready,
    output uart_pkg::byte_t tx_byte,
    output logic            tx_byte_valid,
    input  logic            tx_ready
);

    localparam int NW = $clog2(uart_pkg::BYTES_PER_WORD);

    logic           busy;
    logic [NW-1:0]  idx;
    dbg_pkg::word_t hold;

    assign reply_ready   = !busy;
    assign tx_byte_valid = busy;
    assign tx_byte       = hold[7:0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            idx  <= '0;
        end
        else if (!busy)
        begin
            idx <= '0;
            if (reply_valid)
                busy <= 1'b1;
        end
        else if (tx_ready)
        begin
            idx <= idx + 1'b1;
            if (idx == NW'(uart_pkg::BYTES_PER_WORD - 1))
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && reply_valid)
            hold <= reply_word;
        else if (busy && tx_ready)
            hold <= {8'h00, hold[31:8]};
    end

    // byte held steady until the transmitter takes it
    a_hold_byte: assert property (@(posedge clk) disable iff (rst)
        tx_byte_valid && !tx_ready |=> tx_byte_valid && $stable(tx_byte));

endmodule

/* logic/debug_control.sv */
`timescale 1ns/1ps

module debug_control #(
    parameter int NUM_REGS    = 32,
    parameter int LATCH_WORDS = 21
) (
    input  logic                           clk,
    input  logic                           rst,
    input  dbg_pkg::word_t                 rx_word,
    input  logic                           rx_word_valid,
    output logic                           rx_word_ready,
    output dbg_pkg::word_t                 reply_word,
    output logic                           reply_valid,
    input  logic                           reply_ready,
    output logic                           stall,
    output logic                           imem_we,
    output logic [15:0]                    imem_addr,
    output dbg_pkg::word_t                 imem_wdata,
    input  dbg_pkg::word_t                 pc_value,
    output logic [$clog2(NUM_REGS)-1:0]    reg_addr,
    input  dbg_pkg::word_t                 reg_rdata,
    output logic [15:0]                    mem_addr,
    input  dbg_pkg::word_t                 mem_rdata,
    output logic [$clog2(LATCH_WORDS)-1:0] latch_sel,
    input  dbg_pkg::word_t                 latch_rdata
);

    localparam int RW = $clog2(NUM_REGS);
    localparam int LW = $clog2(LATCH_WORDS);

    localparam logic [2:0] S_IDLE       = 3'd0;
    localparam logic [2:0] S_LOAD       = 3'd1;
    localparam logic [2:0] S_STEP       = 3'd2;
    localparam logic [2:0] S_REPLY      = 3'd3;
    localparam logic [2:0] S_DUMP_PC    = 3'd4;
    localparam logic [2:0] S_DUMP_REG   = 3'd5;
    localparam logic [2:0] S_DUMP_MEM   = 3'd6;
    localparam logic [2:0] S_DUMP_LATCH = 3'd7;

    logic [2:0]        state;
    logic [7:0]        cmd_count;
    logic [7:0]        left;
    logic [15:0]       base;
    logic [1:0]        rd_pipe;
    logic              rd_done;
    logic              rx_take;
    logic              reply_take;
    dbg_pkg::rx_word_u rx_u;

    assign rx_u       = rx_word;
    assign rx_take    = rx_word_valid && rx_word_ready;
    assign reply_take = reply_valid && reply_ready;
    // core read data settles two edges after an address change
    assign rd_done    = rd_pipe[1];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state         <= S_IDLE;
            rx_word_ready <= 1'b0;
            reply_word    <= '0;
            reply_valid   <= 1'b0;
            stall         <= 1'b1;
            imem_we       <= 1'b0;
            imem_addr     <= '0;
            imem_wdata    <= '0;
            reg_addr      <= '0;
            mem_addr      <= '0;
            latch_sel     <= '0;
            cmd_count     <= '0;
            left          <= '0;
            base          <= '0;
            rd_pipe       <= '0;
        end
        else
        begin
            imem_we <= 1'b0;
            rd_pipe <= {rd_pipe[0], 1'b0};
            case (state)
                ////////////////////////////////////////////////////////////////////////////
                // command decode
                S_IDLE:
                begin
                    rx_word_ready <= 1'b1;
                    if (rx_take)
                    begin
                        cmd_count     <= rx_u.cmd.count;
                        left          <= rx_u.cmd.count;
                        base          <= rx_u.cmd.arg;
                        rx_word_ready <= 1'b0;
                        case (rx_u.cmd.opcode)
                            dbg_pkg::OP_LOAD:
                                if (rx_u.cmd.count != 8'd0)
                                begin
                                    rx_word_ready <= 1'b1;
                                    state         <= S_LOAD;
                                end
                                else
                                begin
                                    reply_word  <= dbg_pkg::REPLY_ACK;
                                    reply_valid <= 1'b1;
                                    state       <= S_REPLY;
                                end
                            dbg_pkg::OP_STEP:
                                if (rx_u.cmd.count != 8'd0)
                                begin
                                    stall <= 1'b0;
                                    state <= S_STEP;
                                end
                                else
                                begin
                                    reply_word  <= dbg_pkg::REPLY_ACK;
                                    reply_valid <= 1'b1;
                                    state       <= S_REPLY;
                                end
                            dbg_pkg::OP_DUMP:
                            begin
                                reply_word  <= pc_value;
                                reply_valid <= 1'b1;
                                state       <= S_DUMP_PC;
                            end
                            default:
                            begin
                                reply_word  <= dbg_pkg::REPLY_ERR | {24'd0, rx_u.cmd.opcode};
                                reply_valid <= 1'b1;
                                state       <= S_REPLY;
                            end
                        endcase
                    end
                end
                // same word now read as an instruction
                S_LOAD:
                    if (rx_take)
                    begin
                        imem_we    <= 1'b1;
                        imem_addr  <= base;
                        imem_wdata <= rx_u.instr;
                        base       <= base + 1'b1;
                        left       <= left - 1'b1;
                        if (left == 8'd1)
                        begin
                            rx_word_ready <= 1'b0;
                            reply_word    <= dbg_pkg::REPLY_ACK | {24'd0, cmd_count};
                            reply_valid   <= 1'b1;
                            state         <= S_REPLY;
                        end
                    end
                S_STEP:
                begin
                    left <= left - 1'b1;
                    if (left == 8'd1)
                    begin
                        stall       <= 1'b1;
                        reply_word  <= dbg_pkg::REPLY_ACK | {24'd0, cmd_count};
                        reply_valid <= 1'b1;
                        state       <= S_REPLY;
                    end
                end
                S_REPLY:
                    if (reply_take)
                    begin
                        reply_valid <= 1'b0;
                        state       <= S_IDLE;
                    end
                ////////////////////////////////////////////////////////////////////////////
                // dump walk, one read per reply word
                S_DUMP_PC:
                    if (reply_take)
                    begin
                        reply_valid <= 1'b0;
                        reg_addr    <= '0;
                        rd_pipe     <= 2'b01;
                        state       <= S_DUMP_REG;
                    end
                S_DUMP_REG:
                    if (rd_done)
                    begin
                        reply_word  <= reg_rdata;
                        reply_valid <= 1'b1;
                    end
                    else if (reply_take)
                    begin
                        reply_valid <= 1'b0;
                        rd_pipe     <= 2'b01;
                        if (reg_addr != RW'(NUM_REGS - 1))
                            reg_addr <= reg_addr + 1'b1;
                        else if (cmd_count == 8'd0)
                        begin
                            latch_sel <= '0;
                            state     <= S_DUMP_LATCH;
                        end
                        else
                        begin
                            mem_addr <= base;
                            state    <= S_DUMP_MEM;
                        end
                    end
                S_DUMP_MEM:
                    if (rd_done)
                    begin
                        reply_word  <= mem_rdata;
                        reply_valid <= 1'b1;
                    end
                    else if (reply_take)
                    begin
                        reply_valid <= 1'b0;
                        rd_pipe     <= 2'b01;
                        left        <= left - 1'b1;
                        if (left == 8'd1)
                        begin
                            latch_sel <= '0;
                            state     <= S_DUMP_LATCH;
                        end
                        else
                            mem_addr <= mem_addr + 1'b1;
                    end
                default:
                    if (rd_done)
                    begin
                        reply_word  <= latch_rdata;
                        reply_valid <= 1'b1;
                    end
                    else if (reply_take)
                    begin
                        reply_valid <= 1'b0;
                        rd_pipe     <= 2'b01;
                        if (latch_sel == LW'(LATCH_WORDS - 1))
                            state <= S_IDLE;
                        else
                            latch_sel <= latch_sel + 1'b1;
                    end
            endcase
        end
    end

    // core stays held while instruction words go in
    a_we_from_load: assert property (@(posedge clk) disable iff (rst)
        imem_we |-> stall && (state == S_LOAD || state == S_REPLY));

    a_stall_in_step: assert property (@(posedge clk) disable iff (rst)
        !stall |-> state == S_STEP && left != 8'd0);

endmodule

/* logic/debug_unit_top.sv */
`timescale 1ns/1ps

module debug_unit_top #(
    parameter int CLKS_PER_BIT = 4,
    parameter int NUM_REGS     = 32,
    parameter int LATCH_WORDS  = 21
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rx,
    output logic                           tx,
    output logic                           stall,
    output logic                           imem_we,
    output logic [15:0]                    imem_addr,
    output dbg_pkg::word_t                 imem_wdata,
    input  dbg_pkg::word_t                 pc_value,
    output logic [$clog2(NUM_REGS)-1:0]    reg_addr,
    input  dbg_pkg::word_t                 reg_rdata,
    output logic [15:0]                    mem_addr,
    input  dbg_pkg::word_t                 mem_rdata,
    output logic [$clog2(LATCH_WORDS)-1:0] latch_sel,
    input  dbg_pkg::word_t                 latch_rdata
);

    uart_pkg::byte_t rx_byte;
    logic            rx_byte_valid;
    dbg_pkg::word_t  rx_word;
    logic            rx_word_valid;
    logic            rx_word_ready;
    dbg_pkg::word_t  reply_word;
    logic            reply_valid;
    logic            reply_ready;
    uart_pkg::byte_t tx_byte;
    logic            tx_byte_valid;
    logic            tx_ready;

    ////////////////////////////////////////////////////////////////////////////
    // host to core
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid)
    );

    word_assembler u_asm (
        .clk           (clk),
        .rst           (rst),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .rx_word_ready (rx_word_ready)
    );

    debug_control #(
        .NUM_REGS    (NUM_REGS),
        .LATCH_WORDS (LATCH_WORDS)
    ) u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .rx_word_ready (rx_word_ready),
        .reply_word    (reply_word),
        .reply_valid   (reply_valid),
        .reply_ready   (reply_ready),
        .stall         (stall),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_wdata    (imem_wdata),
        .pc_value      (pc_value),
        .reg_addr      (reg_addr),
        .reg_rdata     (reg_rdata),
        .mem_addr      (mem_addr),
        .mem_rdata     (mem_rdata),
        .latch_sel     (latch_sel),
        .latch_rdata   (latch_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // replies back to the host
    word_serializer u_ser (
        .clk           (clk),
        .rst           (rst),
        .reply_word    (reply_word),
        .reply_valid   (reply_valid),
        .reply_ready   (reply_ready),
        .tx_byte       (tx_byte),
        .tx_byte_valid (tx_byte_valid),
        .tx_ready      (tx_ready)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk           (clk),
        .rst           (rst),
        .tx_byte       (tx_byte),
        .tx_byte_valid (tx_byte_valid),
        .tx_ready      (tx_ready),
        .tx            (tx)
    );

endmodule

/* dv/debug_unit_tb.sv */
`timescale 1ns/1ps

module debug_unit_tb;

    localparam int          CLKS_PER_BIT = 4;
    localparam int          NUM_REGS     = 32;
    localparam int          LATCH_WORDS  = 21;
    localparam int          SCRIPT_DEPTH = 64;
    localparam int          BYTE_TIMEOUT = 2000;
    localparam logic [31:0] REG_BASE     = 32'hA500_0000;
    localparam logic [31:0] LATCH_BASE   = 32'h1A70_0000;

    logic           clk;
    logic           rst         = 1'b1;
    logic           rx          = 1'b1;
    logic           tx;
    logic           stall;
    logic           imem_we;
    logic [15:0]    imem_addr;
    dbg_pkg::word_t imem_wdata;
    dbg_pkg::word_t pc_value    = '0;
    logic [4:0]     reg_addr;
    dbg_pkg::word_t reg_rdata   = '0;
    logic [15:0]    mem_addr;
    dbg_pkg::word_t mem_rdata   = '0;
    logic [4:0]     latch_sel;
    dbg_pkg::word_t latch_rdata = '0;

    dbg_pkg::word_t core_mem [0:65535];
    dbg_pkg::word_t ref_mem  [0:65535];
    logic [35:0]    script   [0:SCRIPT_DEPTH-1];
    logic [47:0]    write_q     [$];
    int             step_expect [$];
    int             step_runs   [$];
    int             low_run     = 0;
    int             load_left   = 0;
    logic [15:0]    load_addr   = '0;
    logic [15:0]    dump_arg    = '0;
    int             dump_count  = 0;
    int             checks      = 0;
    int             errors      = 0;
    logic           timed_out   = 1'b0;

    debug_unit_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .NUM_REGS     (NUM_REGS),
        .LATCH_WORDS  (LATCH_WORDS)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .tx          (tx),
        .stall       (stall),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .pc_value    (pc_value),
        .reg_addr    (reg_addr),
        .reg_rdata   (reg_rdata),
        .mem_addr    (mem_addr),
        .mem_rdata   (mem_rdata),
        .latch_sel   (latch_sel),
        .latch_rdata (latch_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // core model, all reads registered
    always @(posedge clk)
    begin
        if (rst)
            pc_value <= '0;
        else if (!stall)
            pc_value <= pc_value + 32'd1;
        reg_rdata   <= REG_BASE + 32'(reg_addr);
        latch_rdata <= LATCH_BASE + 32'(latch_sel);
        mem_rdata   <= core_mem[mem_addr];
        if (imem_we)
            core_mem[imem_addr] <= imem_wdata;
    end

    // instruction writes against the words the host loaded
    always @(negedge clk)
    begin
        logic [47:0] exp_write;
        if (!rst && imem_we)
        begin
            if (write_q.size() == 0)
            begin
                errors++;
                $display("instruction write to 0x%04h that no load asked for", imem_addr);
            end
            else
            begin
                exp_write = write_q.pop_front();
                check_value("imem_addr", 32'(imem_addr), 32'(exp_write[47:32]));
                check_value("imem_wdata", imem_wdata, exp_write[31:0]);
            end
        end
    end

    // length of each stretch with stall low
    always @(negedge clk)
    begin
        if (!rst && !stall)
            low_run++;
        else if (low_run != 0)
        begin
            step_runs.push_back(low_run);
            low_run = 0;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s expected 0x%08h got 0x%08h", name, exp, got);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // serial host
    task automatic send_byte(input logic [7:0] b);
        repeat (($urandom % 8) * CLKS_PER_BIT) @(negedge clk);
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++)
        begin
            rx = b[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_word(input dbg_pkg::word_t w);
        @(negedge clk);
        for (int k = 0; k < 4; k++)
            send_byte(w[8*k +: 8]);
    endtask

    task automatic recv_byte(output logic [7:0] b);
        int waited;
        waited = 0;
        b      = 8'h00;
        // nothing more to wait for once the link has gone quiet
        if (!timed_out)
        begin
            while (tx !== 1'b0 && waited < BYTE_TIMEOUT)
            begin
                @(negedge clk);
                waited++;
            end
            if (tx !== 1'b0)
            begin
                errors++;
                timed_out = 1'b1;
                $display("timeout waiting for a start bit on tx");
            end
            else
            begin
                // move to mid-bit, then one bit time per sample
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++)
                begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                checks++;
                if (tx !== 1'b1)
                begin
                    errors++;
                    $display("stop bit on tx is low");
                end
            end
        end
    endtask

    task automatic recv_word(output dbg_pkg::word_t w);
        logic [7:0] b;
        for (int k = 0; k < 4; k++)
        begin
            recv_byte(b);
            w[8*k +: 8] = b;
        end
    endtask

    // follow the command stream to know loads, steps and dump windows
    task automatic track_host_word(input dbg_pkg::word_t w);
        if (load_left != 0)
        begin
            write_q.push_back({load_addr, w});
            ref_mem[load_addr] = w;
            load_addr = load_addr + 16'd1;
            load_left--;
        end
        else if (w[31:24] == dbg_pkg::OP_LOAD && w[23:16] != 8'd0)
        begin
            load_left = int'(w[23:16]);
            load_addr = w[15:0];
        end
        else if (w[31:24] == dbg_pkg::OP_STEP && w[23:16] != 8'd0)
            step_expect.push_back(int'(w[23:16]));
        else if (w[31:24] == dbg_pkg::OP_DUMP)
        begin
            dump_arg   = w[15:0];
            dump_count = int'(w[23:16]);
        end
    endtask

    task automatic check_dump(input dbg_pkg::word_t exp_pc);
        dbg_pkg::word_t got;
        recv_word(got);
        if (!timed_out)
            check_value("pc_value", got, exp_pc);
        for (int r = 0; r < NUM_REGS && !timed_out; r++)
        begin
            recv_word(got);
            if (!timed_out)
                check_value("reg_rdata", got, REG_BASE + 32'(r));
        end
        for (int m = 0; m < dump_count && !timed_out; m++)
        begin
            recv_word(got);
            if (!timed_out)
                check_value("mem_rdata", got, ref_mem[16'(dump_arg + 16'(m))]);
        end
        for (int l = 0; l < LATCH_WORDS && !timed_out; l++)
        begin
            recv_word(got);
            if (!timed_out)
                check_value("latch_rdata", got, LATCH_BASE + 32'(l));
        end
    endtask

    initial
    begin
        dbg_pkg::word_t got;
        for (int i = 0; i < SCRIPT_DEPTH; i++)
            script[i] = '0;
        $readmemh("dv/debug_input.txt", script);
        void'($urandom(75492));
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("stall", 32'(stall), 32'd1);
        check_value("imem_we", 32'(imem_we), 32'd0);
        check_value("tx", 32'(tx), 32'd1);

        // tag 0 marks the end of the script
        for (int i = 0; i < SCRIPT_DEPTH && script[i][35:32] != 4'h0 && !timed_out; i++)
        begin
            case (script[i][35:32])
                4'h5:
                begin
                    track_host_word(script[i][31:0]);
                    send_word(script[i][31:0]);
                end
                4'hE:
                begin
                    recv_word(got);
                    if (!timed_out)
                        check_value("reply_word", got, script[i][31:0]);
                end
                4'hD:
                    check_dump(script[i][31:0]);
                default:
                begin
                    errors++;
                    $display("unknown tag %h in input entry %0d", script[i][35:32], i);
                end
            endcase
        end

        checks++;
        if (write_q.size() != 0)
        begin
            errors++;
            $display("%0d loaded words were never written", write_q.size());
        end
        checks++;
        if (step_runs.size() != step_expect.size())
        begin
            errors++;
            $display("%0d stall low stretches seen for %0d step commands",
                     step_runs.size(), step_expect.size());
        end
        else
        begin
            for (int s = 0; s < step_runs.size(); s++)
                check_value("stall low cycles", 32'(step_runs[s]), 32'(step_expect[s]));
        end
        finish_run();
    end

endmodule

/* dv/debug_input.txt */
// first hex digit is the tag, the other eight digits are the word
// tag 5 sends the word, E expects it as a reply, D expects a full dump with this pc
501030010  // load 3 words at 0x0010
500000013
500a00093
500108113
EACC00003
502050000  // step 5 cycles
EACC00005
503020011  // dump with 2 memory words from 0x0011
D00000005
57f000000  // unknown opcode
EEE00007f
502030000  // step right after the error
EACC00003
501020100  // load 2 words at 0x0100
5deadbeef
5cafef00d
EACC00002
5ff000000  // another unknown opcode
EEE0000ff
503020100  // dump with 2 memory words from 0x0100
D00000008

/* build.f */
logic/uart_pkg.sv
logic/dbg_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/word_assembler.sv
logic/word_serializer.sv
logic/debug_control.sv
logic/debug_unit_top.sv
dv/debug_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module debug_unit_tb \
    -f build.f -o debug_unit_sim > build.log 2>&1 \
    || { cat build.log; echo "compile error"; exit 1; }
./obj_dir/debug_unit_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation done"; exit 0; }
